//--- Makefile
.PHONY: all compile run clean

LOG := sim.log

all: run

compile:
	verilator --binary --timing --assert -j 0 -f sources.f --top-module tb_id_stage -Mdir obj_dir

run: compile
	./obj_dir/Vtb_id_stage +verilator+error+limit+100 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- id_bypass.sv
`timescale 1ns/1ps

module id_bypass (
    input  rv_isa_pkg::reg_addr_t reg1_raddr_i,
    input  rv_isa_pkg::reg_addr_t reg2_raddr_i,
    input  rv_isa_pkg::word_t     rs1_rdata_i,
    input  rv_isa_pkg::word_t     rs2_rdata_i,
    input  logic                  ex_reg_we_i,
    input  rv_isa_pkg::reg_addr_t ex_reg_waddr_i,
    input  rv_isa_pkg::word_t     ex_reg_wdata_i,
    input  logic                  mem_reg_we_i,
    input  rv_isa_pkg::reg_addr_t mem_reg_waddr_i,
    input  rv_isa_pkg::word_t     mem_reg_wdata_i,
    input  logic                  wb_reg_we_i,
    input  rv_isa_pkg::reg_addr_t wb_reg_waddr_i,
    input  rv_isa_pkg::word_t     wb_reg_wdata_i,
    input  logic                  ex_is_load_i,
    output rv_isa_pkg::word_t     rs1_val_o,
    output rv_isa_pkg::word_t     rs2_val_o,
    output logic                  hazard_o
);
    import rv_isa_pkg::*;
    import id_pipe_pkg::*;

    byp_sel_t sel1;
    byp_sel_t sel2;

    // youngest matching writer wins
    function automatic byp_sel_t pick_src(reg_addr_t raddr);
        byp_sel_t sel;
        sel = BYP_RF;
        if (raddr != REG_ZERO) begin
            if (ex_reg_we_i && (ex_reg_waddr_i == raddr))
                sel = BYP_EX;
            else if (mem_reg_we_i && (mem_reg_waddr_i == raddr))
                sel = BYP_MEM;
            else if (wb_reg_we_i && (wb_reg_waddr_i == raddr))
                sel = BYP_WB;
        end
        return sel;
    endfunction

    function automatic word_t byp_mux(byp_sel_t sel, reg_addr_t raddr, word_t rf_data);
        word_t val;
        case (sel)
            BYP_EX:  val = ex_reg_wdata_i;
            BYP_MEM: val = mem_reg_wdata_i;
            BYP_WB:  val = wb_reg_wdata_i;
            default: val = rf_data;
        endcase
        return (raddr == REG_ZERO) ? WORD_ZERO : val;   // x0 always zero
    endfunction

    always_comb begin
        sel1      = pick_src(reg1_raddr_i);
        sel2      = pick_src(reg2_raddr_i);
        rs1_val_o = byp_mux(sel1, reg1_raddr_i, rs1_rdata_i);
        rs2_val_o = byp_mux(sel2, reg2_raddr_i, rs2_rdata_i);
    end

    // load data not ready until mem, so a reader right behind it must wait
    assign hazard_o = ex_is_load_i && ex_reg_we_i && (ex_reg_waddr_i != REG_ZERO)
                   && ((reg1_raddr_i == ex_reg_waddr_i)
                    || (reg2_raddr_i == ex_reg_waddr_i));

endmodule

//--- id_decoder.sv
`timescale 1ns/1ps

module id_decoder (
    input  rv_isa_pkg::inst_t     inst_i,
    input  rv_isa_pkg::word_t     inst_addr_i,
    input  rv_isa_pkg::word_t     rs1_val_i,      // already bypassed
    input  rv_isa_pkg::word_t     rs2_val_i,
    output rv_isa_pkg::reg_addr_t reg1_raddr_o,
    output rv_isa_pkg::reg_addr_t reg2_raddr_o,
    output logic                  reg_we_o,
    output rv_isa_pkg::reg_addr_t reg_waddr_o,
    output rv_isa_pkg::word_t     op1_o,
    output rv_isa_pkg::word_t     op2_o,
    output rv_isa_pkg::word_t     jmp_base_o,
    output rv_isa_pkg::word_t     jmp_offs_o,
    output rv_isa_pkg::word_t     store_data_o
);
    import rv_isa_pkg::*;

    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_b;
    word_t     imm_u;
    word_t     imm_j;
    logic      legal;
    logic      rd1_used;
    logic      rd2_used;
    logic      we;

    // ------------------------------------------------------------------------
    // fields and immediates
    // ------------------------------------------------------------------------
    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // ------------------------------------------------------------------------
    // format control, independent of register data
    // ------------------------------------------------------------------------
    always_comb begin
        legal    = 1'b1;
        rd1_used = 1'b0;
        rd2_used = 1'b0;
        we       = 1'b0;
        case (opcode)
            OPC_I_ALU:  begin rd1_used = 1'b1; we = 1'b1; end
            OPC_R: begin
                legal    = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                rd1_used = 1'b1;
                rd2_used = 1'b1;
                we       = 1'b1;
            end
            OPC_LOAD: begin
                legal    = F3_LOAD_LEGAL[funct3];
                rd1_used = 1'b1;
                we       = 1'b1;
            end
            OPC_STORE, OPC_BRANCH: begin
                legal    = (opcode == OPC_STORE) ? F3_STORE_LEGAL[funct3]
                                                 : F3_BRANCH_LEGAL[funct3];
                rd1_used = 1'b1;
                rd2_used = 1'b1;
            end
            OPC_JALR: begin
                legal    = (funct3 == F3_JALR_ONLY);
                rd1_used = 1'b1;
                we       = 1'b1;
            end
            OPC_JAL, OPC_LUI, OPC_AUIPC: we = 1'b1;  // no register reads
            default:    legal = 1'b0;
        endcase
    end

    // illegal encodings read nothing and write nothing
    assign reg1_raddr_o = (legal && rd1_used) ? rs1 : REG_ZERO;
    assign reg2_raddr_o = (legal && rd2_used) ? rs2 : REG_ZERO;
    assign reg_we_o     = legal && we;
    assign reg_waddr_o  = (legal && we) ? rd : REG_ZERO;

    // ------------------------------------------------------------------------
    // operand selection
    // ------------------------------------------------------------------------
    always_comb begin
        op1_o        = WORD_ZERO;
        op2_o        = WORD_ZERO;
        jmp_base_o   = WORD_ZERO;
        jmp_offs_o   = WORD_ZERO;
        store_data_o = WORD_ZERO;
        if (legal) begin
            case (opcode)
                OPC_I_ALU, OPC_LOAD: begin
                    op1_o = rs1_val_i;
                    op2_o = imm_i;        // alu operand or load address offset
                end
                OPC_R: begin
                    op1_o = rs1_val_i;
                    op2_o = rs2_val_i;
                end
                OPC_STORE: begin
                    op1_o        = rs1_val_i;
                    op2_o        = imm_s;
                    store_data_o = rs2_val_i;
                end
                OPC_BRANCH: begin
                    op1_o      = rs1_val_i;  // compared in ex
                    op2_o      = rs2_val_i;
                    jmp_base_o = inst_addr_i;
                    jmp_offs_o = imm_b;
                end
                OPC_JAL, OPC_JALR: begin
                    op1_o      = inst_addr_i;   // link value pc + 4
                    op2_o      = INST_BYTES;
                    jmp_base_o = (opcode == OPC_JAL) ? inst_addr_i : rs1_val_i;
                    jmp_offs_o = (opcode == OPC_JAL) ? imm_j : imm_i;
                end
                OPC_LUI: op1_o = imm_u;
                OPC_AUIPC: begin
                    op1_o = inst_addr_i;
                    op2_o = imm_u;
                end
                default: op1_o = WORD_ZERO;
            endcase
        end
    end

endmodule

//--- id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  load_i,         // low loads a bubble
    input  logic                  reg_we_i,
    input  rv_isa_pkg::reg_addr_t reg_waddr_i,
    input  rv_isa_pkg::word_t     op1_i,
    input  rv_isa_pkg::word_t     op2_i,
    input  rv_isa_pkg::word_t     jmp_base_i,
    input  rv_isa_pkg::word_t     jmp_offs_i,
    input  rv_isa_pkg::word_t     store_data_i,
    input  rv_isa_pkg::word_t     inst_addr_i,
    output logic                  ex_valid_o,
    output logic                  ex_reg_we_o,
    output rv_isa_pkg::reg_addr_t ex_reg_waddr_o,
    output rv_isa_pkg::word_t     ex_op1_o,
    output rv_isa_pkg::word_t     ex_op2_o,
    output rv_isa_pkg::word_t     ex_jmp_base_o,
    output rv_isa_pkg::word_t     ex_jmp_offs_o,
    output rv_isa_pkg::word_t     ex_store_data_o,
    output rv_isa_pkg::word_t     ex_inst_addr_o
);
    import rv_isa_pkg::*;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_o      <= 1'b0;
            ex_reg_we_o     <= 1'b0;
            ex_reg_waddr_o  <= REG_ZERO;
            ex_op1_o        <= WORD_ZERO;
            ex_op2_o        <= WORD_ZERO;
            ex_jmp_base_o   <= WORD_ZERO;
            ex_jmp_offs_o   <= WORD_ZERO;
            ex_store_data_o <= WORD_ZERO;
            ex_inst_addr_o  <= WORD_ZERO;
        end else begin
            ex_valid_o      <= load_i;
            ex_reg_we_o     <= load_i && reg_we_i;
            ex_reg_waddr_o  <= load_i ? reg_waddr_i  : REG_ZERO;
            ex_op1_o        <= load_i ? op1_i        : WORD_ZERO;
            ex_op2_o        <= load_i ? op2_i        : WORD_ZERO;
            ex_jmp_base_o   <= load_i ? jmp_base_i   : WORD_ZERO;
            ex_jmp_offs_o   <= load_i ? jmp_offs_i   : WORD_ZERO;
            ex_store_data_o <= load_i ? store_data_i : WORD_ZERO;
            ex_inst_addr_o  <= load_i ? inst_addr_i  : WORD_ZERO;
        end
    end

endmodule

//--- id_monitor.sv
`timescale 1ns/1ps

module id_monitor (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  active_i,
    input  logic                  exp_stall_i,
    input  rv_isa_pkg::reg_addr_t exp_raddr1_i,
    input  rv_isa_pkg::reg_addr_t exp_raddr2_i,
    input  logic                  exp_valid_i,
    input  logic                  exp_we_i,
    input  rv_isa_pkg::reg_addr_t exp_waddr_i,
    input  rv_isa_pkg::word_t     exp_pc_i,
    input  rv_isa_pkg::word_t     exp_op1_i,
    input  rv_isa_pkg::word_t     exp_op2_i,
    input  rv_isa_pkg::word_t     exp_jmp_base_i,
    input  rv_isa_pkg::word_t     exp_jmp_offs_i,
    input  rv_isa_pkg::word_t     exp_store_data_i,
    input  logic                  stall_i,
    input  rv_isa_pkg::reg_addr_t raddr1_i,
    input  rv_isa_pkg::reg_addr_t raddr2_i,
    input  logic                  ex_valid_i,
    input  logic                  ex_reg_we_i,
    input  rv_isa_pkg::reg_addr_t ex_reg_waddr_i,
    input  rv_isa_pkg::word_t     ex_op1_i,
    input  rv_isa_pkg::word_t     ex_op2_i,
    input  rv_isa_pkg::word_t     ex_jmp_base_i,
    input  rv_isa_pkg::word_t     ex_jmp_offs_i,
    input  rv_isa_pkg::word_t     ex_store_data_i,
    input  rv_isa_pkg::word_t     ex_inst_addr_i,
    output int                    err_count_o
);
    import rv_isa_pkg::*;

    int        errors = 0;
    logic      prev_active;
    logic      prev_valid;
    logic      prev_we;
    reg_addr_t prev_waddr;
    word_t     prev_pc;
    word_t     prev_op1;
    word_t     prev_op2;
    word_t     prev_jmp_base;
    word_t     prev_jmp_offs;
    word_t     prev_store_data;

    assign err_count_o = errors;

    task automatic check_val(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("error %s: got %08h expected %08h at %0t", name, got, exp, $time);
        end
    endtask

    // expected outputs of the line presented one cycle earlier
    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_active <= 1'b0;
        end else begin
            prev_active     <= active_i;
            prev_valid      <= exp_valid_i;
            prev_we         <= exp_we_i;
            prev_waddr      <= exp_waddr_i;
            prev_pc         <= exp_pc_i;
            prev_op1        <= exp_op1_i;
            prev_op2        <= exp_op2_i;
            prev_jmp_base   <= exp_jmp_base_i;
            prev_jmp_offs   <= exp_jmp_offs_i;
            prev_store_data <= exp_store_data_i;
        end
    end

    // falling edge, all outputs settled
    always @(negedge clk) begin
        if (!rst_n_i) begin
            check_val("ex_valid_o", {31'b0, ex_valid_i}, WORD_ZERO);
            check_val("ex_reg_we_o", {31'b0, ex_reg_we_i}, WORD_ZERO);
            check_val("ex_reg_waddr_o", {27'b0, ex_reg_waddr_i}, WORD_ZERO);
            check_val("ex_op1_o", ex_op1_i, WORD_ZERO);
            check_val("ex_op2_o", ex_op2_i, WORD_ZERO);
            check_val("ex_jmp_base_o", ex_jmp_base_i, WORD_ZERO);
            check_val("ex_jmp_offs_o", ex_jmp_offs_i, WORD_ZERO);
            check_val("ex_store_data_o", ex_store_data_i, WORD_ZERO);
            check_val("ex_inst_addr_o", ex_inst_addr_i, WORD_ZERO);
        end else begin
            if (active_i) begin
                check_val("stall_o", {31'b0, stall_i}, {31'b0, exp_stall_i});
                // read addresses are combinational, same cycle
                check_val("reg1_raddr_o", {27'b0, raddr1_i}, {27'b0, exp_raddr1_i});
                check_val("reg2_raddr_o", {27'b0, raddr2_i}, {27'b0, exp_raddr2_i});
            end
            if (prev_active) begin
                check_val("ex_valid_o", {31'b0, ex_valid_i}, {31'b0, prev_valid});
                check_val("ex_reg_we_o", {31'b0, ex_reg_we_i}, {31'b0, prev_we});
                check_val("ex_reg_waddr_o", {27'b0, ex_reg_waddr_i}, {27'b0, prev_waddr});
                check_val("ex_op1_o", ex_op1_i, prev_op1);
                check_val("ex_op2_o", ex_op2_i, prev_op2);
                check_val("ex_jmp_base_o", ex_jmp_base_i, prev_jmp_base);
                check_val("ex_jmp_offs_o", ex_jmp_offs_i, prev_jmp_offs);
                check_val("ex_store_data_o", ex_store_data_i, prev_store_data);
                // pc travels only with a loaded instruction
                check_val("ex_inst_addr_o", ex_inst_addr_i, prev_valid ? prev_pc : WORD_ZERO);
            end
        end
    end

endmodule

//--- id_pipe_pkg.sv
package id_pipe_pkg;

    // ------------------------------------------------------------------------
    // operand bypass source select
    // ------------------------------------------------------------------------
    typedef logic [1:0] byp_sel_t;

    localparam byp_sel_t BYP_RF  = 2'd0;  // register file read data
    localparam byp_sel_t BYP_EX  = 2'd1;  // result leaving ex
    localparam byp_sel_t BYP_MEM = 2'd2;
    localparam byp_sel_t BYP_WB  = 2'd3;  // oldest in-flight writer

endpackage

//--- id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                  clk,
    input  logic                  rst_n_i,
    // from fetch
    input  rv_isa_pkg::inst_t     inst_i,
    input  rv_isa_pkg::word_t     inst_addr_i,
    input  logic                  inst_valid_i,
    // register file, read in the same cycle
    input  rv_isa_pkg::word_t     rs1_rdata_i,
    input  rv_isa_pkg::word_t     rs2_rdata_i,
    // later stage write ports
    input  logic                  ex_reg_we_i,
    input  rv_isa_pkg::reg_addr_t ex_reg_waddr_i,
    input  rv_isa_pkg::word_t     ex_reg_wdata_i,
    input  logic                  mem_reg_we_i,
    input  rv_isa_pkg::reg_addr_t mem_reg_waddr_i,
    input  rv_isa_pkg::word_t     mem_reg_wdata_i,
    input  logic                  wb_reg_we_i,
    input  rv_isa_pkg::reg_addr_t wb_reg_waddr_i,
    input  rv_isa_pkg::word_t     wb_reg_wdata_i,
    input  logic                  ex_is_load_i,
    output logic                  stall_o,
    output rv_isa_pkg::reg_addr_t reg1_raddr_o,
    output rv_isa_pkg::reg_addr_t reg2_raddr_o,
    // to execute
    output logic                  ex_valid_o,
    output logic                  ex_reg_we_o,
    output rv_isa_pkg::reg_addr_t ex_reg_waddr_o,
    output rv_isa_pkg::word_t     ex_op1_o,
    output rv_isa_pkg::word_t     ex_op2_o,
    output rv_isa_pkg::word_t     ex_jmp_base_o,
    output rv_isa_pkg::word_t     ex_jmp_offs_o,
    output rv_isa_pkg::word_t     ex_store_data_o,
    output rv_isa_pkg::word_t     ex_inst_addr_o
);
    import rv_isa_pkg::*;

    word_t     rs1_val;
    word_t     rs2_val;
    logic      reg_we;
    reg_addr_t reg_waddr;
    word_t     op1;
    word_t     op2;
    word_t     jmp_base;
    word_t     jmp_offs;
    word_t     store_data;
    logic      hazard;
    logic      load;

    assign stall_o = inst_valid_i && hazard;   // upstream holds the instruction
    assign load    = inst_valid_i && !hazard;

    id_decoder u_decoder (
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .rs1_val_i    (rs1_val),
        .rs2_val_i    (rs2_val),
        .reg1_raddr_o (reg1_raddr_o),
        .reg2_raddr_o (reg2_raddr_o),
        .reg_we_o     (reg_we),
        .reg_waddr_o  (reg_waddr),
        .op1_o        (op1),
        .op2_o        (op2),
        .jmp_base_o   (jmp_base),
        .jmp_offs_o   (jmp_offs),
        .store_data_o (store_data)
    );

    id_bypass u_bypass (
        .reg1_raddr_i    (reg1_raddr_o),
        .reg2_raddr_i    (reg2_raddr_o),
        .rs1_rdata_i     (rs1_rdata_i),
        .rs2_rdata_i     (rs2_rdata_i),
        .ex_reg_we_i     (ex_reg_we_i),
        .ex_reg_waddr_i  (ex_reg_waddr_i),
        .ex_reg_wdata_i  (ex_reg_wdata_i),
        .mem_reg_we_i    (mem_reg_we_i),
        .mem_reg_waddr_i (mem_reg_waddr_i),
        .mem_reg_wdata_i (mem_reg_wdata_i),
        .wb_reg_we_i     (wb_reg_we_i),
        .wb_reg_waddr_i  (wb_reg_waddr_i),
        .wb_reg_wdata_i  (wb_reg_wdata_i),
        .ex_is_load_i    (ex_is_load_i),
        .rs1_val_o       (rs1_val),
        .rs2_val_o       (rs2_val),
        .hazard_o        (hazard)
    );

    id_ex_reg u_ex_reg (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .load_i          (load),
        .reg_we_i        (reg_we),
        .reg_waddr_i     (reg_waddr),
        .op1_i           (op1),
        .op2_i           (op2),
        .jmp_base_i      (jmp_base),
        .jmp_offs_i      (jmp_offs),
        .store_data_i    (store_data),
        .inst_addr_i     (inst_addr_i),
        .ex_valid_o      (ex_valid_o),
        .ex_reg_we_o     (ex_reg_we_o),
        .ex_reg_waddr_o  (ex_reg_waddr_o),
        .ex_op1_o        (ex_op1_o),
        .ex_op2_o        (ex_op2_o),
        .ex_jmp_base_o   (ex_jmp_base_o),
        .ex_jmp_offs_o   (ex_jmp_offs_o),
        .ex_store_data_o (ex_store_data_o),
        .ex_inst_addr_o  (ex_inst_addr_o)
    );

endmodule

//--- id_stage_checker.sv
`timescale 1ns/1ps

module id_stage_checker (
    input logic clk,
    input logic rst_n_i,
    input logic stall_o,
    input logic ex_valid_o,
    input logic ex_reg_we_o
);
    int fail_cnt = 0;

    // a bubble never writes
    a_we_needs_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        !ex_valid_o |-> !ex_reg_we_o)
        else begin $error("ex_reg_we_o high without ex_valid_o"); fail_cnt++; end

    a_bubble_after_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_o |=> !ex_valid_o)
        else begin $error("ex_valid_o high after a stall cycle"); fail_cnt++; end

    a_reset_idle: assert property (@(posedge clk) !rst_n_i |-> !ex_valid_o)
        else begin $error("ex_valid_o high during reset"); fail_cnt++; end

endmodule

bind id_stage id_stage_checker u_checker (.*);

//--- id_trace.txt
// inst pc ctl{valid,load,ex_we,mem_we,wb_we} waddrs{ex,mem,wb} rs1d rs2d exd memd wbd
// flags{stall,valid,we,-,waddr} op1 op2 jmp_base jmp_offs store_data
00510093 00000100 10000000 00000000 11111111 00000000 00000000 00000000 00000000 01100100 11111111 00000005 00000000 00000000 00000000
002081B3 00000104 10000000 00000000 AAAA0000 0000BBBB 00000000 00000000 00000000 01100300 AAAA0000 0000BBBB 00000000 00000000 00000000
40628233 00000108 10000000 00000000 00000010 00000003 00000000 00000000 00000000 01100400 00000010 00000003 00000000 00000000 00000000
02628233 0000010C 10000000 00000000 00000010 00000003 00000000 00000000 00000000 01000000 00000000 00000000 00000000 00000000 00000000
00842383 00000110 10000000 00000000 00001000 00000000 00000000 00000000 00000000 01100700 00001000 00000008 00000000 00000000 00000000
FE952E23 00000114 10000000 00000000 00002000 DEADBEEF 00000000 00000000 00000000 01000000 00002000 FFFFFFFC 00000000 00000000 DEADBEEF
123455B7 00000118 10000000 00000000 00000000 00000000 00000000 00000000 00000000 01100B00 12345000 00000000 00000000 00000000 00000000
00001617 0000011C 10000000 00000000 00000000 00000000 00000000 00000000 00000000 01100C00 0000011C 00001000 00000000 00000000 00000000
00208863 00000120 10000000 00000000 00000005 00000005 00000000 00000000 00000000 01000000 00000005 00000005 00000120 00000010 00000000
008000EF 00000124 10000000 00000000 00000000 00000000 00000000 00000000 00000000 01100100 00000124 00000004 00000124 00000008 00000000
FF8302E7 00000128 10000000 00000000 00004000 00000000 00000000 00000000 00000000 01100500 00000128 00000004 00004000 FFFFFFF8 00000000
00510093 0000012C 10111000 02020200 11111111 00000000 E0E0E0E0 0E0E0E0E BBBB0000 01100100 E0E0E0E0 00000005 00000000 00000000 00000000
00510093 00000130 10011000 02020200 11111111 00000000 E0E0E0E0 0E0E0E0E BBBB0000 01100100 0E0E0E0E 00000005 00000000 00000000 00000000
00510093 00000134 10001000 02020200 11111111 00000000 E0E0E0E0 0E0E0E0E BBBB0000 01100100 BBBB0000 00000005 00000000 00000000 00000000
00500093 00000138 10111000 00000000 00000055 00000000 E0E0E0E0 0E0E0E0E BBBB0000 01100100 00000000 00000005 00000000 00000000 00000000
002081B3 0000013C 11100000 02000000 AAAA0000 0000BBBB 77777777 00000000 00000000 10000000 00000000 00000000 00000000 00000000 00000000
002081B3 0000013C 10100000 02000000 AAAA0000 0000BBBB 77777777 00000000 00000000 01100300 AAAA0000 77777777 00000000 00000000 00000000
00510093 00000140 00000000 00000000 11111111 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
002081B3 00000140 01100000 02000000 AAAA0000 0000BBBB 77777777 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00510093 00000140 10000000 00000000 11111111 00000000 00000000 00000000 00000000 01100100 11111111 00000005 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

//--- rv_isa_pkg.sv
package rv_isa_pkg;

    // ------------------------------------------------------------------------
    // field widths
    // ------------------------------------------------------------------------
    typedef logic [31:0] word_t;      // data or address word
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // ------------------------------------------------------------------------
    // major opcodes, rv32i base
    // ------------------------------------------------------------------------
    localparam opcode_t OPC_I_ALU  = 7'b0010011;
    localparam opcode_t OPC_R      = 7'b0110011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;

    localparam reg_addr_t REG_ZERO   = 5'd0;      // x0, hardwired zero
    localparam word_t     WORD_ZERO  = 32'h0;
    localparam word_t     INST_BYTES = 32'd4;     // pc step, also link offset

    localparam funct7_t F7_BASE      = 7'b0000000;
    localparam funct7_t F7_ALT       = 7'b0100000;  // sub, sra
    localparam funct3_t F3_JALR_ONLY = 3'b000;

    // legal funct3 values, bit n set when funct3 == n is defined
    localparam logic [7:0] F3_LOAD_LEGAL   = 8'b0011_0111;  // lb lh lw lbu lhu
    localparam logic [7:0] F3_STORE_LEGAL  = 8'b0000_0111;  // sb sh sw
    localparam logic [7:0] F3_BRANCH_LEGAL = 8'b1111_0011;  // 2 and 3 unused

endpackage

//--- sources.f
rv_isa_pkg.sv
id_pipe_pkg.sv
id_decoder.sv
id_bypass.sv
id_ex_reg.sv
id_stage.sv
id_stage_checker.sv
id_monitor.sv
tb_id_stage.sv

//--- tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
    import rv_isa_pkg::*;

    localparam int WORDS_PER_LINE = 15;
    localparam int NUM_LINES      = 21;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = NUM_LINES + RESET_CYCLES + 20;

    word_t trace_mem [0:NUM_LINES*WORDS_PER_LINE-1];

    logic      clk;
    logic      rst_n_i;
    inst_t     inst;
    word_t     inst_addr;
    logic      inst_valid;
    word_t     rs1_rdata;
    word_t     rs2_rdata;
    logic      ex_reg_we;
    reg_addr_t ex_reg_waddr;
    word_t     ex_reg_wdata;
    logic      mem_reg_we;
    reg_addr_t mem_reg_waddr;
    word_t     mem_reg_wdata;
    logic      wb_reg_we;
    reg_addr_t wb_reg_waddr;
    word_t     wb_reg_wdata;
    logic      ex_is_load;

    logic      stall;
    reg_addr_t reg1_raddr;
    reg_addr_t reg2_raddr;
    logic      ex_valid;
    logic      ex_we;
    reg_addr_t ex_waddr;
    word_t     ex_op1;
    word_t     ex_op2;
    word_t     ex_jmp_base;
    word_t     ex_jmp_offs;
    word_t     ex_store_data;
    word_t     ex_inst_addr;

    // expected fields of the line being driven
    logic      line_active;
    logic      exp_stall;
    reg_addr_t exp_raddr1;
    reg_addr_t exp_raddr2;
    logic      exp_valid;
    logic      exp_we;
    reg_addr_t exp_waddr;
    word_t     exp_pc;
    word_t     exp_op1;
    word_t     exp_op2;
    word_t     exp_jmp_base;
    word_t     exp_jmp_offs;
    word_t     exp_store_data;

    int        mon_errors;
    int        cycle_cnt = 0;

    always #5 clk = ~clk;

    id_stage DUT (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .inst_i          (inst),
        .inst_addr_i     (inst_addr),
        .inst_valid_i    (inst_valid),
        .rs1_rdata_i     (rs1_rdata),
        .rs2_rdata_i     (rs2_rdata),
        .ex_reg_we_i     (ex_reg_we),
        .ex_reg_waddr_i  (ex_reg_waddr),
        .ex_reg_wdata_i  (ex_reg_wdata),
        .mem_reg_we_i    (mem_reg_we),
        .mem_reg_waddr_i (mem_reg_waddr),
        .mem_reg_wdata_i (mem_reg_wdata),
        .wb_reg_we_i     (wb_reg_we),
        .wb_reg_waddr_i  (wb_reg_waddr),
        .wb_reg_wdata_i  (wb_reg_wdata),
        .ex_is_load_i    (ex_is_load),
        .stall_o         (stall),
        .reg1_raddr_o    (reg1_raddr),
        .reg2_raddr_o    (reg2_raddr),
        .ex_valid_o      (ex_valid),
        .ex_reg_we_o     (ex_we),
        .ex_reg_waddr_o  (ex_waddr),
        .ex_op1_o        (ex_op1),
        .ex_op2_o        (ex_op2),
        .ex_jmp_base_o   (ex_jmp_base),
        .ex_jmp_offs_o   (ex_jmp_offs),
        .ex_store_data_o (ex_store_data),
        .ex_inst_addr_o  (ex_inst_addr)
    );

    id_monitor u_monitor (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .active_i         (line_active),
        .exp_stall_i      (exp_stall),
        .exp_raddr1_i     (exp_raddr1),
        .exp_raddr2_i     (exp_raddr2),
        .exp_valid_i      (exp_valid),
        .exp_we_i         (exp_we),
        .exp_waddr_i      (exp_waddr),
        .exp_pc_i         (exp_pc),
        .exp_op1_i        (exp_op1),
        .exp_op2_i        (exp_op2),
        .exp_jmp_base_i   (exp_jmp_base),
        .exp_jmp_offs_i   (exp_jmp_offs),
        .exp_store_data_i (exp_store_data),
        .stall_i          (stall),
        .raddr1_i         (reg1_raddr),
        .raddr2_i         (reg2_raddr),
        .ex_valid_i       (ex_valid),
        .ex_reg_we_i      (ex_we),
        .ex_reg_waddr_i   (ex_waddr),
        .ex_op1_i         (ex_op1),
        .ex_op2_i         (ex_op2),
        .ex_jmp_base_i    (ex_jmp_base),
        .ex_jmp_offs_i    (ex_jmp_offs),
        .ex_store_data_i  (ex_store_data),
        .ex_inst_addr_i   (ex_inst_addr),
        .err_count_o      (mon_errors)
    );

    // ------------------------------------------------------------------------
    // trace line to DUT inputs and expected fields
    // ------------------------------------------------------------------------

    // source registers an instruction reads, x0 where unused or illegal
    function automatic void expected_reads(input inst_t word, output reg_addr_t ra1,
                                           output reg_addr_t ra2);
        logic [2:0] f3;
        logic       use1;
        logic       use2;
        f3   = word[14:12];
        use1 = 1'b0;
        use2 = 1'b0;
        case (word[6:0])
            OPC_I_ALU: use1 = 1'b1;
            OPC_R: begin
                use1 = (word[31:25] == 7'h00) || (word[31:25] == 7'h20);
                use2 = use1;
            end
            OPC_LOAD: use1 = (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
            OPC_STORE: begin
                use1 = (f3 <= 3'd2);      // sb sh sw
                use2 = use1;
            end
            OPC_BRANCH: begin
                use1 = (f3 != 3'd2) && (f3 != 3'd3);
                use2 = use1;
            end
            OPC_JALR: use1 = (f3 == 3'd0);
            default:  use1 = 1'b0;
        endcase
        ra1 = use1 ? word[19:15] : 5'd0;
        ra2 = use2 ? word[24:20] : 5'd0;
    endfunction

    task automatic apply_line(input int idx);
        int base;
        word_t ctl;
        word_t addrs;
        word_t flags;
        reg_addr_t ra1;
        reg_addr_t ra2;
        base  = idx * WORDS_PER_LINE;
        ctl   = trace_mem[base+2];
        addrs = trace_mem[base+3];
        flags = trace_mem[base+9];
        expected_reads(trace_mem[base], ra1, ra2);
        inst          <= trace_mem[base];
        inst_addr     <= trace_mem[base+1];
        inst_valid    <= ctl[28];
        ex_is_load    <= ctl[24];
        ex_reg_we     <= ctl[20];
        mem_reg_we    <= ctl[16];
        wb_reg_we     <= ctl[12];
        ex_reg_waddr  <= addrs[28:24];
        mem_reg_waddr <= addrs[20:16];
        wb_reg_waddr  <= addrs[12:8];
        rs1_rdata     <= trace_mem[base+4];
        rs2_rdata     <= trace_mem[base+5];
        ex_reg_wdata  <= trace_mem[base+6];
        mem_reg_wdata <= trace_mem[base+7];
        wb_reg_wdata  <= trace_mem[base+8];
        line_active    <= 1'b1;
        exp_stall      <= flags[28];
        exp_raddr1     <= ra1;
        exp_raddr2     <= ra2;
        exp_valid      <= flags[24];
        exp_we         <= flags[20];
        exp_waddr      <= flags[12:8];
        exp_pc         <= trace_mem[base+1];
        exp_op1        <= trace_mem[base+10];
        exp_op2        <= trace_mem[base+11];
        exp_jmp_base   <= trace_mem[base+12];
        exp_jmp_offs   <= trace_mem[base+13];
        exp_store_data <= trace_mem[base+14];
    endtask

    task automatic end_run();
        int assert_errors;
        assert_errors = DUT.u_checker.fail_cnt;
        $display("errors: monitor %0d, assertions %0d", mon_errors, assert_errors);
        if ((mon_errors == 0) && (assert_errors == 0)) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        clk            = 1'b0;
        rst_n_i        = 1'b0;
        inst           = '0;
        inst_addr      = '0;
        inst_valid     = 1'b0;
        rs1_rdata      = '0;
        rs2_rdata      = '0;
        ex_is_load     = 1'b0;
        ex_reg_we      = 1'b0;
        ex_reg_waddr   = '0;
        ex_reg_wdata   = '0;
        mem_reg_we     = 1'b0;
        mem_reg_waddr  = '0;
        mem_reg_wdata  = '0;
        wb_reg_we      = 1'b0;
        wb_reg_waddr   = '0;
        wb_reg_wdata   = '0;
        line_active    = 1'b0;
        exp_stall      = 1'b0;
        exp_raddr1     = '0;
        exp_raddr2     = '0;
        exp_valid      = 1'b0;
        exp_we         = 1'b0;
        exp_waddr      = '0;
        exp_pc         = '0;
        exp_op1        = '0;
        exp_op2        = '0;
        exp_jmp_base   = '0;
        exp_jmp_offs   = '0;
        exp_store_data = '0;
        $readmemh("id_trace.txt", trace_mem);

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        for (int i = 0; i < NUM_LINES; i++) begin
            @(posedge clk);
            apply_line(i);
        end
        @(posedge clk);
        line_active <= 1'b0;  // last line's outputs still checked
        inst_valid  <= 1'b0;
        @(posedge clk);
        end_run();
    end

endmodule
